// File: Makefile
BIN := obj_dir/Vsoc_tb
SRCS := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): soc_top.f $(SRCS)
	verilator --binary --timing --top-module soc_tb -f soc_top.f --Mdir obj_dir -o Vsoc_tb

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: design/bram_slave.sv
`timescale 1ns/100ps
`include "soc_consts.svh"

module bram_slave import bus_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_i,
	input wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int DEPTH = 1 << `SOC_BRAM_AW;

	logic [31:0] mem [0:DEPTH-1];
	logic [`SOC_BRAM_AW-1:0] word_adr;
	logic [31:0] dat_r;
	logic ack;
	logic access;

	// word index from the byte offset
	assign word_adr = req_i.adr.wb.offset[`SOC_BRAM_AW+1:2];

	// ack still high means stb is the one just served
	assign access = req_i.cyc & req_i.stb & ~ack & ~sys_rst_i;

	//----------------------------------------
	// storage
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (access & req_i.we) begin
			for (int b = 0; b < 4; b++) begin
				// byte lanes
				if (req_i.sel[b]) begin
					mem[word_adr][8*b +: 8] <= req_i.dat_w[8*b +: 8];
				end
			end
		end
		if (access) begin
			dat_r <= mem[word_adr];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	assign rsp_o.dat_r = dat_r;
	assign rsp_o.ack = ack;
	assign rsp_o.err = 1'b0;

endmodule

// File: design/bus_pkg.sv
package bus_pkg;

	// wishbone view of the address
	// bit 31 ignored so the upper half shadows the lower half
	typedef struct packed {
		logic ignored;
		logic [1:0] region;
		logic [28:0] offset;
	} wb_view_t;

	// CSR view of the same word
	// bank and register form the 14 bit CSR address
	typedef struct packed {
		logic [15:0] high;
		logic [3:0] bank;
		logic [9:0] reg_num;
		logic [1:0] lane;
	} csr_view_t;

	typedef union packed {
		wb_view_t wb;
		csr_view_t csr;
	} wb_addr_u;

	// master to slave
	typedef struct packed {
		wb_addr_u adr;
		logic [31:0] dat_w;
		logic [3:0] sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// slave to master
	// err only ever rides along with ack
	typedef struct packed {
		logic [31:0] dat_r;
		logic ack;
		logic err;
	} wb_rsp_t;

endpackage

// File: design/csr_bridge.sv
`timescale 1ns/100ps

module csr_bridge import bus_pkg::*, csr_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_i,
	input wb_req_t req_i,
	output wb_rsp_t rsp_o,
	output csr_req_t csr_o,
	input logic [31:0] csr_dr_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PRESENT,
		ST_CAPTURE
	} brg_state_t;

	brg_state_t state;
	logic ack;
	logic [31:0] dat_r;

	//----------------------------------------
	// sequencer
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			ack <= 1'b0;
			csr_o.we <= 1'b0;
		end else begin
			ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					// ack high means this stb was just served
					if (req_i.cyc & req_i.stb & ~ack) begin
						csr_o.we <= req_i.we;
						state <= ST_PRESENT;
					end
				end
				ST_PRESENT: begin
					// write strobe lasts one cycle
					csr_o.we <= 1'b0;
					state <= ST_CAPTURE;
				end
				ST_CAPTURE: begin
					ack <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// address and data held through the cycle
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE) begin
			csr_o.a <= {req_i.adr.csr.bank, req_i.adr.csr.reg_num};
			csr_o.dw <= req_i.dat_w;
		end
		// slave data is one cycle behind the address
		if (state == ST_CAPTURE) begin
			dat_r <= csr_dr_i;
		end
	end

	assign rsp_o.dat_r = dat_r;
	assign rsp_o.ack = ack;
	assign rsp_o.err = 1'b0;

endmodule

// File: design/csr_pkg.sv
`include "soc_consts.svh"

package csr_pkg;

	// one CSR cycle
	// we is a single cycle strobe
	typedef struct packed {
		logic [`SOC_CSR_AW-1:0] a;
		logic we;
		logic [31:0] dw;
	} csr_req_t;

	// system control bits out of the sysctl bank
	typedef struct packed {
		logic bus_errors_en;
		logic hard_reset_req;
	} sysctl_ctrl_t;

endpackage

// File: design/soc_bus_decode.sv
`timescale 1ns/100ps
`include "soc_consts.svh"

module soc_bus_decode import bus_pkg::*, csr_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_i,
	input wb_req_t req_i,
	output wb_rsp_t rsp_o,
	input sysctl_ctrl_t ctrl_i,
	output wb_req_t bram_req_o,
	input wb_rsp_t bram_rsp_i,
	output wb_req_t csr_req_o,
	input wb_rsp_t csr_rsp_i
);

	logic sel_bram;
	logic sel_csr;
	logic sel_none;
	logic hit_none;
	logic is_null;
	logic none_ack;
	logic none_err;

	//----------------------------------------
	// region decode
	//----------------------------------------
	// top bit ignored here
	assign sel_bram = req_i.adr.wb.region == `SOC_REGION_BRAM;
	assign sel_csr = req_i.adr.wb.region == `SOC_REGION_CSR;
	assign sel_none = ~sel_bram & ~sel_csr;

	// null window does include bit 31
	assign is_null = req_i.adr[31 -: `SOC_NULL_BITS] == '0;

	// forward path has no register
	// only the chosen target sees cyc and stb
	always_comb begin
		bram_req_o = req_i;
		bram_req_o.cyc = req_i.cyc & sel_bram;
		bram_req_o.stb = req_i.stb & sel_bram;
		csr_req_o = req_i;
		csr_req_o.cyc = req_i.cyc & sel_csr;
		csr_req_o.stb = req_i.stb & sel_csr;
	end

	//----------------------------------------
	// unmapped regions
	//----------------------------------------
	// one cycle ack, held off for a cycle after each ack
	assign hit_none = req_i.cyc & req_i.stb & sel_none & ~none_ack;

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			none_ack <= 1'b0;
			none_err <= 1'b0;
		end else begin
			none_ack <= hit_none;
			// null access flagged only when enabled
			none_err <= hit_none & is_null & ctrl_i.bus_errors_en;
		end
	end

	// response back to the master
	always_comb begin
		if (sel_bram) begin
			rsp_o = bram_rsp_i;
		end else if (sel_csr) begin
			rsp_o = csr_rsp_i;
		end else begin
			rsp_o.dat_r = 32'd0;
			rsp_o.ack = none_ack;
			rsp_o.err = none_err;
		end
	end

endmodule

// File: design/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

//----------------------------------------
// address map
//----------------------------------------

// region codes in bits 30:29, bit 31 ignored
`define SOC_REGION_BRAM 2'b10
`define SOC_REGION_CSR 2'b11

// null pointer window is the top 14 address bits all zero
`define SOC_NULL_BITS 14

// block RAM word address width
`define SOC_BRAM_AW 8

//----------------------------------------
// reset counters
//----------------------------------------

// system reset stretch
`define SOC_DEBOUNCE_BITS 8
// flash reset released at the top bit
`define SOC_FLASH_RST_BITS 8

//----------------------------------------
// CSR bus
//----------------------------------------
`define SOC_CSR_AW 14
`define SOC_CSR_BANK_SYSCTL 4'd1
`define SOC_SYSTEM_ID 32'h13004D31
// button synchronizer depth
`define SOC_SYNC_STAGES 2

`endif

// File: design/soc_reset.sv
`timescale 1ns/100ps
`include "soc_consts.svh"

module soc_reset import csr_pkg::*; (
	input logic sys_clk,
	input logic trigger_reset,
	input logic [2:0] btn_i,
	input sysctl_ctrl_t ctrl_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	logic chord;
	logic trig_r;
	logic [`SOC_DEBOUNCE_BITS-1:0] deb_cnt;
	logic [`SOC_FLASH_RST_BITS-1:0] flash_cnt;

	// all three buttons pressed together
	assign chord = &btn_i;

	//----------------------------------------
	// combined reset request
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		trig_r <= trigger_reset | chord | ctrl_i.hard_reset_req;
	end

	// reload while any source is up, then count down to zero
	// reload value makes up for the source register
	always_ff @(posedge sys_clk) begin
		if (trig_r) begin
			deb_cnt <= {{(`SOC_DEBOUNCE_BITS-1){1'b1}}, 1'b0};
		end else if (deb_cnt != '0) begin
			deb_cnt <= deb_cnt - 1'b1;
		end
	end

	// high from the cycle after a source until the count runs out
	assign sys_rst_o = trig_r | (|deb_cnt);

	//----------------------------------------
	// flash reset
	//----------------------------------------
	// counts up from one and stops once the top bit sets
	always_ff @(posedge sys_clk) begin
		if (trig_r) begin
			flash_cnt <= {{(`SOC_FLASH_RST_BITS-1){1'b0}}, 1'b1};
		end else if (!flash_cnt[`SOC_FLASH_RST_BITS-1]) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
	end

	// released half way through the system reset
	assign flash_rst_n_o = flash_cnt[`SOC_FLASH_RST_BITS-1] & ~trig_r;

endmodule

// File: design/soc_top.sv
`timescale 1ns/100ps

module soc_top import bus_pkg::*, csr_pkg::*; (
	input logic sys_clk,
	input logic trigger_reset,
	input logic [2:0] btn_i,
	input wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o,
	output logic [7:0] led_o,
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);

	logic sys_rst;
	sysctl_ctrl_t ctrl;
	wb_req_t bram_req;
	wb_rsp_t bram_rsp;
	wb_req_t brg_req;
	wb_rsp_t brg_rsp;
	csr_req_t csr_req;
	logic [31:0] csr_dr;

	//----------------------------------------
	// reset
	//----------------------------------------
	soc_reset u_reset (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.btn_i(btn_i),
		.ctrl_i(ctrl),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	//----------------------------------------
	// bus and targets
	//----------------------------------------
	soc_bus_decode u_decode (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.req_i(wb_req_i),
		.rsp_o(wb_rsp_o),
		.ctrl_i(ctrl),
		.bram_req_o(bram_req),
		.bram_rsp_i(bram_rsp),
		.csr_req_o(brg_req),
		.csr_rsp_i(brg_rsp)
	);

	bram_slave u_bram (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.req_i(bram_req),
		.rsp_o(bram_rsp)
	);

	csr_bridge u_csrbrg (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.req_i(brg_req),
		.rsp_o(brg_rsp),
		.csr_o(csr_req),
		.csr_dr_i(csr_dr)
	);

	// system controller on the CSR bus
	sysctl_csr u_sysctl (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_i(csr_req),
		.csr_dr_o(csr_dr),
		.btn_i(btn_i),
		.led_o(led_o),
		.ctrl_o(ctrl)
	);

endmodule

// File: design/sysctl_csr.sv
`timescale 1ns/100ps
`include "soc_consts.svh"

module sysctl_csr import csr_pkg::*; (
	input logic sys_clk,
	input logic sys_rst_i,
	input csr_req_t csr_i,
	output logic [31:0] csr_dr_o,
	input logic [2:0] btn_i,
	output logic [7:0] led_o,
	output sysctl_ctrl_t ctrl_o
);

	logic [`SOC_SYNC_STAGES-1:0][2:0] btn_sync;
	logic bank_hit;
	logic [9:0] reg_num;

	// bank field sits on top of the CSR address
	assign bank_hit = csr_i.a[`SOC_CSR_AW-1 -: 4] == `SOC_CSR_BANK_SYSCTL;
	assign reg_num = csr_i.a[9:0];

	// button synchronizer
	always_ff @(posedge sys_clk) begin
		btn_sync <= {btn_sync[`SOC_SYNC_STAGES-2:0], btn_i};
	end

	//----------------------------------------
	// read side
	//----------------------------------------
	// other banks read zero so the bus can be ORed
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= 32'd0;
		if (bank_hit) begin
			case (reg_num)
				10'd0: csr_dr_o <= {29'd0, btn_sync[`SOC_SYNC_STAGES-1]};
				10'd1: csr_dr_o <= {24'd0, led_o};
				10'd2: csr_dr_o <= `SOC_SYSTEM_ID;
				10'd3: csr_dr_o <= {30'd0, ctrl_o.hard_reset_req, ctrl_o.bus_errors_en};
				default: csr_dr_o <= 32'd0;
			endcase
		end
	end

	//----------------------------------------
	// write side
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= 8'd0;
			ctrl_o.bus_errors_en <= 1'b0;
			// the reset this raises also clears it
			ctrl_o.hard_reset_req <= 1'b0;
		end else if (bank_hit & csr_i.we) begin
			case (reg_num)
				10'd1: led_o <= csr_i.dw[7:0];
				10'd3: begin
					ctrl_o.bus_errors_en <= csr_i.dw[0];
					// set only, never cleared by software
					if (csr_i.dw[1]) begin
						ctrl_o.hard_reset_req <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: soc_top.f
+incdir+design
design/bus_pkg.sv
design/csr_pkg.sv
design/soc_reset.sv
design/soc_bus_decode.sv
design/bram_slave.sv
design/csr_bridge.sv
design/sysctl_csr.sv
design/soc_top.sv
tests/soc_tb.sv

// File: tests/soc_tb.sv
`timescale 1ns/100ps
`include "soc_consts.svh"

module soc_tb
	import bus_pkg::*;
();

	localparam int NWORDS = 24;

	logic sys_clk;
	logic trigger_reset;
	logic [2:0] btn_i;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [7:0] led_o;
	logic flash_rst_n_o;
	logic periph_rst_n_o;

	// reference state of the SoC
	logic [31:0] ref_mem [0:(1 << `SOC_BRAM_AW)-1];
	logic [7:0] ref_led;
	logic [2:0] ref_btn;
	logic ref_err_en;

	// expected response of the access in flight
	logic exp_armed;
	logic exp_chk_dat;
	logic [31:0] exp_dat;
	logic exp_err;

	logic [31:0] rng;
	logic [31:0] ram_adr [0:NWORDS-1];

	soc_top u_dut (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.btn_i(btn_i),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.led_o(led_o),
		.flash_rst_n_o(flash_rst_n_o),
		.periph_rst_n_o(periph_rst_n_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	//----------------------------------------
	// helpers
	//----------------------------------------
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic compare_values(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s got 0x%h expected 0x%h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// sysctl register address, bank in bits 15:12
	function automatic logic [31:0] sysctl_adr(input logic [9:0] r);
		return {1'b0, `SOC_REGION_CSR, 13'd0, `SOC_CSR_BANK_SYSCTL, r, 2'b00};
	endfunction

	//----------------------------------------
	// reference model
	//----------------------------------------
	// expected read data, bit 31 plays no part in the region
	function automatic logic [31:0] ref_read(input logic [31:0] adr);
		logic [31:0] r;
		r = 32'd0;
		if (adr[30:29] == `SOC_REGION_BRAM) begin
			r = ref_mem[adr[`SOC_BRAM_AW+1:2]];
		end else if (adr[30:29] == `SOC_REGION_CSR &&
				adr[15:12] == `SOC_CSR_BANK_SYSCTL) begin
			case (adr[11:2])
				10'd0: r = {29'd0, ref_btn};
				10'd1: r = {24'd0, ref_led};
				10'd2: r = `SOC_SYSTEM_ID;
				10'd3: r = {31'd0, ref_err_en};
				default: r = 32'd0;
			endcase
		end
		return r;
	endfunction

	// err only on unmapped null accesses with checking on
	function automatic logic ref_err(input logic [31:0] adr);
		return adr[30:29] != `SOC_REGION_BRAM && adr[30:29] != `SOC_REGION_CSR &&
			adr[31 -: `SOC_NULL_BITS] == '0 && ref_err_en;
	endfunction

	function automatic int exp_latency(input logic [31:0] adr);
		return (adr[30:29] == `SOC_REGION_CSR) ? 3 : 1;
	endfunction

	task automatic ref_write(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		logic [`SOC_BRAM_AW-1:0] w;
		w = adr[`SOC_BRAM_AW+1:2];
		if (adr[30:29] == `SOC_REGION_BRAM) begin
			for (int b = 0; b < 4; b++) begin
				if (sel[b]) begin
					ref_mem[w][8*b +: 8] = dat[8*b +: 8];
				end
			end
		end else if (adr[30:29] == `SOC_REGION_CSR &&
				adr[15:12] == `SOC_CSR_BANK_SYSCTL) begin
			if (adr[11:2] == 10'd1) begin
				ref_led = dat[7:0];
			end
			if (adr[11:2] == 10'd3) begin
				ref_err_en = dat[0];
			end
		end
	endtask

	// registers cleared by the system reset, RAM kept
	task automatic ref_reset();
		ref_led = 8'd0;
		ref_err_en = 1'b0;
	endtask

	//----------------------------------------
	// bus master
	//----------------------------------------
	task automatic bus_access(input logic [31:0] adr, input logic we, input logic [31:0] dat,
			input logic [3:0] sel, input logic chk_dat);
		int lat;
		lat = 0;
		@(negedge sys_clk);
		// last ack cleared a cycle ago so the compare process is idle
		exp_chk_dat = chk_dat;
		exp_dat = ref_read(adr);
		exp_err = ref_err(adr);
		exp_armed = 1'b1;
		wb_req.adr = adr;
		wb_req.dat_w = dat;
		wb_req.sel = sel;
		wb_req.we = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		do begin
			@(negedge sys_clk);
			lat++;
			if (lat > 16) begin
				abort_run("bus access timed out waiting for ack");
			end
		end while (wb_rsp.ack !== 1'b1);
		compare_values("ack latency", lat, exp_latency(adr));
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
		if (we) begin
			ref_write(adr, dat, sel);
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (periph_rst_n_o !== 1'b1) begin
			@(negedge sys_clk);
			n++;
			if (n > 600) begin
				abort_run("system reset was never released");
			end
		end
	endtask

	task automatic ram_readback();
		for (int i = 0; i < NWORDS; i++) begin
			bus_access(ram_adr[i], 1'b0, 32'd0, 4'h0, 1'b1);
			// upper half shadows the lower half
			bus_access(ram_adr[i] | 32'h8000_0000, 1'b0, 32'd0, 4'h0, 1'b1);
		end
	endtask

	// response compare, sampled mid cycle
	always @(negedge sys_clk) begin
		if (exp_armed && wb_rsp.ack === 1'b1) begin
			exp_armed = 1'b0;
			if (exp_chk_dat) begin
				compare_values("wb_rsp_o.dat_r", wb_rsp.dat_r, exp_dat);
			end
			compare_values("wb_rsp_o.err", {31'd0, wb_rsp.err}, {31'd0, exp_err});
		end
	end

	//----------------------------------------
	// stimulus
	//----------------------------------------
	initial begin
		int cnt;
		int flash_at;
		int periph_at;
		logic [3:0] sel;
		trigger_reset = 1'b1;
		btn_i = 3'd0;
		wb_req = '0;
		exp_armed = 1'b0;
		exp_chk_dat = 1'b0;
		exp_dat = 32'd0;
		exp_err = 1'b0;
		rng = 32'd99;
		ref_led = 8'd0;
		ref_btn = 3'd0;
		ref_err_en = 1'b0;

		// reset held 8 cycles
		// source needs two edges to reach the registers
		for (int i = 0; i < 8; i++) begin
			@(negedge sys_clk);
			if (i >= 2) begin
				compare_values("led_o", {24'd0, led_o}, 32'd0);
				compare_values("wb_rsp_o.ack", {31'd0, wb_rsp.ack}, 32'd0);
			end
		end
		trigger_reset = 1'b0;

		// release timing counted from the trigger drop
		cnt = 0;
		flash_at = 0;
		periph_at = 0;
		while (periph_at == 0) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > 600) begin
				abort_run("reset release never seen on periph_rst_n_o");
			end
			compare_values("led_o", {24'd0, led_o}, 32'd0);
			compare_values("wb_rsp_o.ack", {31'd0, wb_rsp.ack}, 32'd0);
			if (flash_rst_n_o === 1'b1 && flash_at == 0) begin
				flash_at = cnt;
			end
			if (periph_rst_n_o === 1'b1) begin
				periph_at = cnt;
			end
		end
		compare_values("flash_rst_n_o rise", flash_at, 128);
		compare_values("periph_rst_n_o rise", periph_at, (1 << `SOC_DEBOUNCE_BITS) - 1);

		// block RAM, full words first so no byte stays unknown
		for (int i = 0; i < NWORDS; i++) begin
			rng = xorshift(rng);
			ram_adr[i] = {1'b0, `SOC_REGION_BRAM, rng[28:2], 2'b00};
			rng = xorshift(rng);
			bus_access(ram_adr[i], 1'b1, rng, 4'hf, 1'b0);
		end
		for (int i = 0; i < NWORDS; i++) begin
			rng = xorshift(rng);
			sel = rng[3:0];
			rng = xorshift(rng);
			bus_access(ram_adr[i], 1'b1, rng, sel, 1'b0);
		end
		ram_readback();

		// CSR bank
		bus_access(sysctl_adr(10'd2), 1'b0, 32'd0, 4'h0, 1'b1);
		rng = xorshift(rng);
		bus_access(sysctl_adr(10'd1), 1'b1, {24'd0, rng[7:0]}, 4'hf, 1'b0);
		compare_values("led_o", {24'd0, led_o}, {24'd0, ref_led});
		bus_access(sysctl_adr(10'd1), 1'b0, 32'd0, 4'h0, 1'b1);
		btn_i = 3'b101;
		ref_btn = btn_i;
		repeat (`SOC_SYNC_STAGES) @(negedge sys_clk);
		bus_access(sysctl_adr(10'd0), 1'b0, 32'd0, 4'h0, 1'b1);
		btn_i = 3'b010;
		ref_btn = btn_i;
		repeat (`SOC_SYNC_STAGES) @(negedge sys_clk);
		bus_access(sysctl_adr(10'd0), 1'b0, 32'd0, 4'h0, 1'b1);

		// null pointer errors
		bus_access(32'h0000_1230, 1'b0, 32'd0, 4'h0, 1'b1);
		bus_access(sysctl_adr(10'd3), 1'b1, 32'd1, 4'hf, 1'b0);
		bus_access(sysctl_adr(10'd3), 1'b0, 32'd0, 4'h0, 1'b1);
		bus_access(32'h0000_1230, 1'b0, 32'd0, 4'h0, 1'b1);
		// unmapped but outside the null window
		bus_access(32'h2000_0040, 1'b0, 32'd0, 4'h0, 1'b1);
		bus_access(32'h8000_0100, 1'b0, 32'd0, 4'h0, 1'b1);

		// button chord reset
		bus_access(sysctl_adr(10'd1), 1'b1, 32'h0000_00a5, 4'hf, 1'b0);
		@(negedge sys_clk);
		btn_i = 3'b111;
		repeat (4) @(negedge sys_clk);
		compare_values("periph_rst_n_o", {31'd0, periph_rst_n_o}, 32'd0);
		compare_values("flash_rst_n_o", {31'd0, flash_rst_n_o}, 32'd0);
		btn_i = 3'd0;
		ref_btn = 3'd0;
		ref_reset();
		wait_reset_release();
		compare_values("led_o", {24'd0, led_o}, 32'd0);
		bus_access(sysctl_adr(10'd3), 1'b0, 32'd0, 4'h0, 1'b1);
		bus_access(sysctl_adr(10'd1), 1'b0, 32'd0, 4'h0, 1'b1);
		ram_readback();

		// software hard reset, the write itself still acks
		bus_access(sysctl_adr(10'd1), 1'b1, 32'h0000_005a, 4'hf, 1'b0);
		bus_access(sysctl_adr(10'd3), 1'b1, 32'd3, 4'hf, 1'b0);
		compare_values("periph_rst_n_o", {31'd0, periph_rst_n_o}, 32'd0);
		compare_values("flash_rst_n_o", {31'd0, flash_rst_n_o}, 32'd0);
		ref_reset();
		wait_reset_release();
		compare_values("led_o", {24'd0, led_o}, 32'd0);
		bus_access(sysctl_adr(10'd3), 1'b0, 32'd0, 4'h0, 1'b1);
		ram_readback();

		// one more edge so the last response gets compared
		@(negedge sys_clk);
		if (exp_armed) begin
			abort_run("a bus response was never compared");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule
